//--- fpmul_params.svh
`ifndef FPMUL_PARAMS_SVH
`define FPMUL_PARAMS_SVH

`define FP_W 32
`define MANT_W 24 // significand including the hidden bit.
`define PROD_W 48
`define SHIFT_W 6
`define EXP_W 8
`define EXP_BIAS 127
`define MUL_CYCLES 24 // one shift-add step per multiplier bit.
`define QNAN 32'h7FC0_0000

`endif

//--- fpmul_pkg.sv
package fpmul_pkg;

	// controller states.
	typedef enum logic [2:0]
	{
		IDLE,
		MUL,
		ALIGN,
		ROUND,
		DONE
	} ctrl_state_e;

	typedef enum logic
	{
		OP_FMUL,
		OP_FNMUL // sign of the product is inverted.
	} op_e;

	// operand classes that bypass the arithmetic path.
	typedef enum logic [1:0]
	{
		SP_NONE,
		SP_ZERO,
		SP_INF,
		SP_NAN
	} special_e;

endpackage

//--- fpmul_dp_if.sv
interface fpmul_dp_if;

	logic load; // operands and opcode are captured on this strobe.
	logic mul_step;
	logic mul_done; // marks the step that completes the product.
	logic align_en;
	logic round_en;

	modport ctrl
	(
		output load,
		output mul_step,
		output align_en,
		output round_en,
		input mul_done
	);

	modport mult
	(
		input load,
		input mul_step,
		output mul_done
	);

	// shared by the exponent unit and the rounding stage.
	modport post
	(
		input load,
		input align_en,
		input round_en
	);

endinterface

//--- b_right_shifter.sv
`include "fpmul_params.svh"

module b_right_shifter (
	input logic [`PROD_W-1:0] shift_in,
	input logic [`SHIFT_W-1:0] shift_value,
	output logic [`PROD_W-1:0] shift_out,
	output logic sticky
);

	always_comb
	begin
		case (shift_value)
			0: shift_out = shift_in;
			1: shift_out = shift_in >> 1;
			2: shift_out = shift_in >> 2;
			3: shift_out = shift_in >> 3;
			4: shift_out = shift_in >> 4;
			5: shift_out = shift_in >> 5;
			6: shift_out = shift_in >> 6;
			7: shift_out = shift_in >> 7;
			8: shift_out = shift_in >> 8;
			9: shift_out = shift_in >> 9;
			10: shift_out = shift_in >> 10;
			11: shift_out = shift_in >> 11;
			12: shift_out = shift_in >> 12;
			13: shift_out = shift_in >> 13;
			14: shift_out = shift_in >> 14;
			15: shift_out = shift_in >> 15;
			16: shift_out = shift_in >> 16;
			17: shift_out = shift_in >> 17;
			18: shift_out = shift_in >> 18;
			19: shift_out = shift_in >> 19;
			20: shift_out = shift_in >> 20;
			21: shift_out = shift_in >> 21;
			22: shift_out = shift_in >> 22;
			23: shift_out = shift_in >> 23;
			24: shift_out = shift_in >> 24;
			25: shift_out = shift_in >> 25;
			26: shift_out = shift_in >> 26;
			27: shift_out = shift_in >> 27;
			28: shift_out = shift_in >> 28;
			29: shift_out = shift_in >> 29;
			30: shift_out = shift_in >> 30;
			31: shift_out = shift_in >> 31;
			32: shift_out = shift_in >> 32;
			33: shift_out = shift_in >> 33;
			34: shift_out = shift_in >> 34;
			35: shift_out = shift_in >> 35;
			36: shift_out = shift_in >> 36;
			37: shift_out = shift_in >> 37;
			38: shift_out = shift_in >> 38;
			39: shift_out = shift_in >> 39;
			40: shift_out = shift_in >> 40;
			41: shift_out = shift_in >> 41;
			42: shift_out = shift_in >> 42;
			43: shift_out = shift_in >> 43;
			44: shift_out = shift_in >> 44;
			45: shift_out = shift_in >> 45;
			46: shift_out = shift_in >> 46;
			47: shift_out = shift_in >> 47;
			48: shift_out = shift_in >> 48;
			default: shift_out = '0;
		endcase
	end

	// any one lost off the bottom shows up as a mismatch after shifting back.
	assign sticky = ((shift_out << shift_value) != shift_in);

endmodule

//--- fpmul_ctrl.sv
`include "fpmul_params.svh"

module fpmul_ctrl (
	input logic clk,
	input logic rst_n,
	input logic start,
	fpmul_dp_if.ctrl dp,
	output logic busy,
	output logic done
);

	fpmul_pkg::ctrl_state_e state_q;
	fpmul_pkg::ctrl_state_e state_d;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state_q <= fpmul_pkg::IDLE;
		else
			state_q <= state_d;
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			fpmul_pkg::IDLE:
			begin
				if (start)
					state_d = fpmul_pkg::MUL;
			end
			fpmul_pkg::MUL:
			begin
				if (dp.mul_done) // last step is taken on this edge.
					state_d = fpmul_pkg::ALIGN;
			end
			fpmul_pkg::ALIGN:
			begin
				state_d = fpmul_pkg::ROUND;
			end
			fpmul_pkg::ROUND:
			begin
				state_d = fpmul_pkg::DONE;
			end
			fpmul_pkg::DONE:
			begin
				state_d = fpmul_pkg::IDLE;
			end
			default:
			begin
				state_d = fpmul_pkg::IDLE;
			end
		endcase
	end

	// a start outside IDLE never reaches the datapath.
	assign dp.load = (state_q == fpmul_pkg::IDLE) && start;
	assign dp.mul_step = (state_q == fpmul_pkg::MUL);
	assign dp.align_en = (state_q == fpmul_pkg::ALIGN);
	assign dp.round_en = (state_q == fpmul_pkg::ROUND);

	assign busy = (state_q != fpmul_pkg::IDLE);
	assign done = (state_q == fpmul_pkg::DONE);

	// the result register must have been written on the cycle before done.
	a_done_after_round: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(dp.round_en))
		else $error("done raised without a preceding round strobe");

	// the multiplier has to report completion on the last MUL cycle.
	a_mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
		dp.load |-> ##(`MUL_CYCLES) dp.mul_done)
		else $error("mul_done did not arrive the expected number of cycles after load");

endmodule

//--- mant_multiplier.sv
`include "fpmul_params.svh"

module mant_multiplier (
	input logic clk,
	input logic rst_n,
	fpmul_dp_if.mult dp,
	input logic [`MANT_W-1:0] mant_a,
	input logic [`MANT_W-1:0] mant_b,
	output logic [`PROD_W-1:0] product
);

	localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

	logic [`MANT_W-1:0] mcand_q;
	logic [`PROD_W-1:0] acc_q; // upper half is the partial sum, lower half the multiplier.
	logic [CNT_W-1:0] cnt_q;
	logic [`MANT_W:0] part_sum;

	// add the multiplicand when the current multiplier bit is set.
	assign part_sum = {1'b0, acc_q[`PROD_W-1:`MANT_W]} + (acc_q[0] ? {1'b0, mcand_q} : '0);

	always_ff @(posedge clk)
	begin
		if (dp.load)
		begin
			mcand_q <= mant_a;
			acc_q <= {{`MANT_W{1'b0}}, mant_b};
		end
		else if (dp.mul_step)
			acc_q <= {part_sum, acc_q[`MANT_W-1:1]}; // shift right by one as the sum lands.
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cnt_q <= '0;
		else if (dp.load)
			cnt_q <= '0;
		else if (dp.mul_step)
			cnt_q <= cnt_q + 1'b1;
	end

	assign dp.mul_done = dp.mul_step && (cnt_q == CNT_W'(`MUL_CYCLES - 1));
	assign product = acc_q;

	// an extra step would shift the finished product out of place.
	a_no_step_after_done: assert property (@(posedge clk) disable iff (!rst_n)
		dp.mul_done |=> !dp.mul_step)
		else $error("mul_step arrived after the product was complete");

endmodule

//--- exp_unit.sv
`include "fpmul_params.svh"

module exp_unit (
	input logic clk,
	input logic rst_n,
	fpmul_dp_if.post dp,
	input logic [`FP_W-1:0] a,
	input logic [`FP_W-1:0] b,
	input fpmul_pkg::op_e op,
	output logic [`MANT_W-1:0] mant_a,
	output logic [`MANT_W-1:0] mant_b,
	output logic sign,
	output logic signed [`EXP_W+1:0] exp_sum,
	output logic [`SHIFT_W-1:0] shift_value,
	output fpmul_pkg::special_e special
);

	logic [`EXP_W-1:0] ea;
	logic [`EXP_W-1:0] eb;
	logic zero_a;
	logic zero_b;
	logic inf_a;
	logic inf_b;
	logic nan_a;
	logic nan_b;
	logic signed [`EXP_W+1:0] exp_calc;
	logic signed [`EXP_W+1:0] shift_full;
	logic [`SHIFT_W-1:0] shift_calc;
	fpmul_pkg::special_e special_calc;

	assign ea = a[`FP_W-2 -: `EXP_W];
	assign eb = b[`FP_W-2 -: `EXP_W];

	assign zero_a = (ea == '0); // subnormal inputs are flushed to zero.
	assign zero_b = (eb == '0);
	assign inf_a = (ea == '1) && (a[`MANT_W-2:0] == '0);
	assign inf_b = (eb == '1) && (b[`MANT_W-2:0] == '0);
	assign nan_a = (ea == '1) && (a[`MANT_W-2:0] != '0);
	assign nan_b = (eb == '1) && (b[`MANT_W-2:0] != '0);

	// the multiplier samples these directly on load.
	assign mant_a = zero_a ? '0 : {1'b1, a[`MANT_W-2:0]};
	assign mant_b = zero_b ? '0 : {1'b1, b[`MANT_W-2:0]};

	assign exp_calc = (`EXP_W+2)'(ea) + (`EXP_W+2)'(eb) - (`EXP_W+2)'(`EXP_BIAS);
	assign shift_full = $signed((`EXP_W+2)'(1)) - exp_calc;

	always_comb
	begin
		if (exp_calc > 0)
			shift_calc = '0;
		else if (shift_full > `PROD_W)
			shift_calc = `SHIFT_W'(`PROD_W); // everything shifts into sticky.
		else
			shift_calc = shift_full[`SHIFT_W-1:0];
	end

	always_comb
	begin
		if (nan_a || nan_b || (inf_a && zero_b) || (inf_b && zero_a))
			special_calc = fpmul_pkg::SP_NAN;
		else if (inf_a || inf_b)
			special_calc = fpmul_pkg::SP_INF;
		else if (zero_a || zero_b)
			special_calc = fpmul_pkg::SP_ZERO;
		else
			special_calc = fpmul_pkg::SP_NONE;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			special <= fpmul_pkg::SP_NONE;
			shift_value <= '0;
		end
		else if (dp.load)
		begin
			special <= special_calc;
			shift_value <= shift_calc;
		end
	end

	always_ff @(posedge clk)
	begin
		if (dp.load)
		begin
			sign <= a[`FP_W-1] ^ b[`FP_W-1] ^ (op == fpmul_pkg::OP_FNMUL);
			exp_sum <= exp_calc;
		end
	end

endmodule

//--- norm_round.sv
`include "fpmul_params.svh"

module norm_round (
	input logic clk,
	input logic rst_n,
	fpmul_dp_if.post dp,
	input logic [`PROD_W-1:0] product,
	input logic sign,
	input logic signed [`EXP_W+1:0] exp_sum,
	input logic [`SHIFT_W-1:0] shift_value,
	input fpmul_pkg::special_e special,
	output logic [`FP_W-1:0] result
);

	localparam int G = `PROD_W - `MANT_W - 1; // guard position when the top bit is set.
	localparam logic signed [`EXP_W+1:0] EXP_MIN = 1;
	localparam logic signed [`EXP_W+1:0] EXP_MAX = (1 << `EXP_W) - 1;

	logic [`PROD_W-1:0] shifted;
	logic shift_sticky;
	logic [`PROD_W-1:0] al_q;
	logic al_sticky_q;
	logic signed [`EXP_W+1:0] al_exp_q;
	logic norm;
	logic [`MANT_W-1:0] mant;
	logic guard;
	logic rnd;
	logic stk;
	logic inc;
	logic [`MANT_W:0] mant_r;
	logic signed [`EXP_W+1:0] exp_r;
	logic hidden;
	logic [`EXP_W-1:0] exp_field;
	logic [`MANT_W-2:0] frac;
	logic [`FP_W-1:0] packed_res;

	b_right_shifter u_shifter (
		.shift_in(product),
		.shift_value(shift_value),
		.shift_out(shifted),
		.sticky(shift_sticky)
	);

	always_ff @(posedge clk)
	begin
		if (dp.align_en)
		begin
			al_q <= shifted;
			al_sticky_q <= shift_sticky;
			al_exp_q <= (shift_value != '0) ? EXP_MIN : exp_sum; // denormalized results sit at 1.
		end
	end

	assign norm = al_q[`PROD_W-1];
	assign mant = norm ? al_q[`PROD_W-1 -: `MANT_W] : al_q[`PROD_W-2 -: `MANT_W];
	assign guard = norm ? al_q[G] : al_q[G-1];
	assign rnd = norm ? al_q[G-1] : al_q[G-2];
	assign stk = (norm ? |al_q[G-2:0] : |al_q[G-3:0]) | al_sticky_q;

	// round to nearest, ties to even.
	assign inc = guard && (rnd || stk || mant[0]);
	assign mant_r = {1'b0, mant} + (`MANT_W+1)'(inc);

	// a carry out of the mantissa moves the exponent up by one.
	assign exp_r = al_exp_q + $signed({{(`EXP_W+1){1'b0}}, norm})
		+ $signed({{(`EXP_W+1){1'b0}}, mant_r[`MANT_W]});
	assign hidden = mant_r[`MANT_W] | mant_r[`MANT_W-1];
	assign exp_field = hidden ? exp_r[`EXP_W-1:0] : '0;
	assign frac = mant_r[`MANT_W] ? mant_r[`MANT_W-1:1] : mant_r[`MANT_W-2:0];

	always_comb
	begin
		case (special)
			fpmul_pkg::SP_NAN: packed_res = `QNAN;
			fpmul_pkg::SP_INF: packed_res = {sign, {`EXP_W{1'b1}}, {(`MANT_W-1){1'b0}}};
			fpmul_pkg::SP_ZERO: packed_res = {sign, {(`FP_W-1){1'b0}}};
			default:
			begin
				if (exp_r >= EXP_MAX)
					packed_res = {sign, {`EXP_W{1'b1}}, {(`MANT_W-1){1'b0}}};
				else
					packed_res = {sign, exp_field, frac};
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			result <= '0;
		else if (dp.round_en)
			result <= packed_res;
	end

	// the exponent unit must saturate before the shifter sees the amount.
	a_shift_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		dp.align_en |-> shift_value <= `PROD_W)
		else $error("shift amount %0d beyond the shifter range", shift_value);

endmodule

//--- fpmul_top.sv
`include "fpmul_params.svh"

module fpmul_top (
	input logic clk,
	input logic rst_n,
	input logic start,
	input fpmul_pkg::op_e op,
	input logic [`FP_W-1:0] a,
	input logic [`FP_W-1:0] b,
	output logic busy,
	output logic done,
	output logic [`FP_W-1:0] result
);

	logic [`MANT_W-1:0] mant_a;
	logic [`MANT_W-1:0] mant_b;
	logic [`PROD_W-1:0] product;
	logic sign;
	logic signed [`EXP_W+1:0] exp_sum;
	logic [`SHIFT_W-1:0] shift_value;
	fpmul_pkg::special_e special;

	fpmul_dp_if dp ();

	fpmul_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.dp(dp.ctrl),
		.busy(busy),
		.done(done)
	);

	mant_multiplier u_mult (
		.clk(clk),
		.rst_n(rst_n),
		.dp(dp.mult),
		.mant_a(mant_a),
		.mant_b(mant_b),
		.product(product)
	);

	exp_unit u_exp (
		.clk(clk),
		.rst_n(rst_n),
		.dp(dp.post),
		.a(a),
		.b(b),
		.op(op),
		.mant_a(mant_a),
		.mant_b(mant_b),
		.sign(sign),
		.exp_sum(exp_sum),
		.shift_value(shift_value),
		.special(special)
	);

	norm_round u_round (
		.clk(clk),
		.rst_n(rst_n),
		.dp(dp.post),
		.product(product),
		.sign(sign),
		.exp_sum(exp_sum),
		.shift_value(shift_value),
		.special(special),
		.result(result)
	);

endmodule

//--- tb_fpmul_top.sv
`include "fpmul_params.svh"

module tb_fpmul_top;

	localparam int N_RAND = 100; // operations per random class.
	localparam int N_DIR = 16;
	localparam int N_OPS = 3 * N_RAND + 2 * N_DIR + 2;
	localparam int DONE_EDGE = `MUL_CYCLES + 3;
	localparam int WATCHDOG_CYCLES = N_OPS * 40 + 1000;

	// each entry holds the operand pair as {a, b}.
	localparam logic [63:0] DIR_VEC [N_DIR] = '{
		64'h00000000_3FC00000, // zero times finite.
		64'h80000000_40490FDB,
		64'h7F800000_3F800000, // inf times finite.
		64'hFF800000_40000000,
		64'h7F800000_00000000, // inf times zero.
		64'h7FC00001_3F800000,
		64'h3F800000_FF800001,
		64'h00400000_7F000000, // subnormal input acts as zero.
		64'h807FFFFF_7F800000,
		64'h7F000000_40000000, // plain overflow.
		64'h7F7FFFFE_3F800001, // rounds up past the largest normal.
		64'h00800000_3F000000,
		64'h00800000_3F7FFFFF, // tie that rounds into the smallest normal.
		64'h00800000_00800000,
		64'h0D000000_0D000000, // shift saturates and the result is zero.
		64'h00800000_33C00000
	};

	logic clk;
	logic rst_n;
	logic start;
	fpmul_pkg::op_e op;
	logic [`FP_W-1:0] a;
	logic [`FP_W-1:0] b;
	logic busy;
	logic done;
	logic [`FP_W-1:0] result;

	logic [5:0] model_cnt; // edges since the accepted start, zero when idle.
	logic [`FP_W-1:0] pend_result;
	logic [`FP_W-1:0] exp_result;
	logic exp_busy;
	logic exp_done;
	logic accepted;
	int value_errs = 0;
	int other_errs = 0;

	fpmul_top DUT (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.busy(busy),
		.done(done),
		.result(result)
	);

	// IEEE single multiply with subnormal inputs flushed, nearest-even rounding.
	function automatic logic [`FP_W-1:0] ref_mul(input logic [31:0] x, input logic [31:0] y,
		input logic neg);
		logic s;
		logic [7:0] ex;
		logic [7:0] ey;
		logic [47:0] p;
		logic [63:0] m;
		logic [63:0] rem;
		logic [63:0] half;
		int e_norm;
		int e_out;
		int drop;
		s = x[31] ^ y[31] ^ neg;
		ex = x[30:23];
		ey = y[30:23];
		if ((ex == 8'hFF && x[22:0] != 0) || (ey == 8'hFF && y[22:0] != 0))
			return `QNAN;
		if ((ex == 8'hFF && ey == 8'h00) || (ey == 8'hFF && ex == 8'h00))
			return `QNAN;
		if (ex == 8'hFF || ey == 8'hFF)
			return {s, 8'hFF, 23'h0};
		if (ex == 8'h00 || ey == 8'h00)
			return {s, 31'h0};
		p = {24'h0, 1'b1, x[22:0]} * {24'h0, 1'b1, y[22:0]};
		e_norm = int'(ex) + int'(ey) - `EXP_BIAS + (p[47] ? 1 : 0);
		if (e_norm >= 1)
		begin
			drop = p[47] ? 24 : 23;
			e_out = e_norm;
		end
		else
		begin
			drop = 151 - int'(ex) - int'(ey); // lsb weight of a subnormal is 2^-149.
			e_out = 0;
		end
		if (drop > 60)
			drop = 60;
		m = {16'h0, p} >> drop;
		rem = {16'h0, p} - (m << drop);
		half = 64'd1 << (drop - 1);
		if (rem > half || (rem == half && m[0]))
			m = m + 64'd1;
		if (m[24])
		begin
			m = m >> 1;
			e_out = e_out + 1;
		end
		else if (e_out == 0 && m[23])
			e_out = 1;
		if (e_out >= 255)
			return {s, 8'hFF, 23'h0};
		return {s, 8'(e_out), m[22:0]};
	endfunction

	function automatic logic [`FP_W-1:0] rand_fp(input int lo, input int hi);
		logic [7:0] e;
		e = 8'(lo + int'($urandom % (hi - lo + 1)));
		return {1'($urandom % 2), e, 23'($urandom)};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expv,
		input logic [31:0] actv);
		$display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, expv, actv);
		value_errs++;
	endtask

	task automatic report_event(input string what);
		$display("ERROR at time %0t: %s", $time, what);
		other_errs++;
	endtask

	task automatic finish_run(input bit timed_out);
		$display("errors: %0d value, %0d protocol, %0d timeout", value_errs, other_errs,
			timed_out);
		if (value_errs == 0 && other_errs == 0 && !timed_out)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	// called #1 after a rising edge and returns #1 after the edge that ends done.
	task automatic run_op(input logic [31:0] x, input logic [31:0] y, input fpmul_pkg::op_e o);
		a = x;
		b = y;
		op = o;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!done);
		@(posedge clk);
		#1;
	endtask

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			model_cnt <= '0;
			exp_result <= '0;
		end
		else if (model_cnt == '0)
		begin
			if (start)
			begin
				model_cnt <= 6'd1;
				pend_result <= ref_mul(a, b, op == fpmul_pkg::OP_FNMUL);
			end
		end
		else if (model_cnt == 6'(DONE_EDGE))
			model_cnt <= '0;
		else
		begin
			model_cnt <= model_cnt + 6'd1;
			if (model_cnt == 6'(DONE_EDGE - 1))
				exp_result <= pend_result; // result lands on the same edge as done.
		end
	end

	assign exp_busy = (model_cnt != '0);
	assign exp_done = (model_cnt == 6'(DONE_EDGE));
	assign accepted = start && (model_cnt == '0);

	a_busy: assert property (@(posedge clk) disable iff (!rst_n) busy == exp_busy)
		else report_mismatch("busy", 32'($sampled(exp_busy)), 32'($sampled(busy)));

	a_done: assert property (@(posedge clk) disable iff (!rst_n) done == exp_done)
		else report_mismatch("done", 32'($sampled(exp_done)), 32'($sampled(done)));

	a_result: assert property (@(posedge clk) disable iff (!rst_n) result == exp_result)
		else report_mismatch("result", $sampled(exp_result), $sampled(result));

	a_latency: assert property (@(posedge clk) disable iff (!rst_n) accepted |-> ##DONE_EDGE done)
		else report_event("done did not rise 27 edges after an accepted start");

	a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> !busy && !done && result == '0)
		else report_event("outputs were not cleared by reset");

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES + 16) @(posedge clk);
		$display("timeout: the operations did not complete in %0d cycles", WATCHDOG_CYCLES);
		finish_run(1'b1);
	end

	initial
	begin
		logic [31:0] x;
		logic [31:0] y;
		int t;
		void'($urandom(32'h04b97b2b));
		rst_n = 1'b0;
		start = 1'b0;
		op = fpmul_pkg::OP_FMUL;
		a = '0;
		b = '0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		for (int i = 0; i < N_RAND; i++)
			run_op(rand_fp(64, 190), rand_fp(64, 190), fpmul_pkg::OP_FMUL);
		for (int i = 0; i < N_RAND; i++)
			run_op(rand_fp(1, 254), rand_fp(1, 254), fpmul_pkg::op_e'($urandom % 2));
		// exponent sums near the bias push results into the subnormal range.
		for (int i = 0; i < N_RAND; i++)
		begin
			x = rand_fp(1, 126);
			t = 100 - int'(x[30:23]) + int'($urandom % 34);
			if (t < 1)
				t = 1;
			y = rand_fp(t, t);
			run_op(x, y, fpmul_pkg::OP_FMUL);
		end
		for (int i = 0; i < N_DIR; i++)
			run_op(DIR_VEC[i][63:32], DIR_VEC[i][31:0], fpmul_pkg::OP_FMUL);
		for (int i = 0; i < N_DIR; i++)
			run_op(DIR_VEC[i][63:32], DIR_VEC[i][31:0], fpmul_pkg::OP_FNMUL);
		// a second start while busy must not disturb the first operation.
		a = 32'h40400000;
		b = 32'hC0A00000;
		op = fpmul_pkg::OP_FMUL;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		run_op(32'h3F800000, 32'h3F800000, fpmul_pkg::OP_FNMUL);
		run_op(32'h41200000, 32'h3E800000, fpmul_pkg::OP_FMUL);
		repeat (4) @(posedge clk);
		finish_run(1'b0);
	end

endmodule

//--- fpmul_top.f
+incdir+.
fpmul_pkg.sv
fpmul_dp_if.sv
b_right_shifter.sv
fpmul_ctrl.sv
mant_multiplier.sv
exp_unit.sv
norm_round.sv
fpmul_top.sv
tb_fpmul_top.sv

//--- Makefile
# Verilator build and run for the floating-point multiplier testbench.

VERILATOR ?= verilator
TOP ?= tb_fpmul_top
FILELIST ?= fpmul_top.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Simulation passed
VFLAGS ?= --binary --timing --assert -Wno-fatal

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
